/* bq_capture.f */
+incdir+design
design/bq_pkg.sv
design/bq_stream_if.sv
design/capture_gate.sv
design/coef_regs.sv
design/zero_fir.sv
design/bq_capture_top.sv
test/bq_capture_properties.sv
test/bq_capture_tb.sv

/* Makefile */
SIM        = verilator
TOP        = bq_capture_tb
FILELIST   = bq_capture.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only -Wall --timing
RUN_FLAGS  = +verilator+error+limit+1000
PASS_MSG   = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* test/bq_capture_tb.sv */
`include "bq_defs.svh"

module bq_capture_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W           = 16 * `BQ_NSAMP;
    localparam int ACK_TIMEOUT = 16;
    localparam int RUN_TIMEOUT = 2 * (`BQ_GATE_DELAY + `BQ_GATE_LEN + `BQ_RST_DELAY);

    logic         aclk;
    logic         rst_i;
    logic         capture_i;
    logic [W-1:0] adc0_tdata_i;
    logic         adc0_tvalid_i;
    logic [W-1:0] adc1_tdata_i;
    logic         adc1_tvalid_i;
    logic [W-1:0] buf0_tdata_o;
    logic         buf0_tvalid_o;
    logic [W-1:0] buf1_tdata_o;
    logic         buf1_tvalid_o;
    logic [W-1:0] buf2_tdata_o;
    logic         buf2_tvalid_o;
    logic [W-1:0] buf3_tdata_o;
    logic         buf3_tvalid_o;
    logic         bus_cyc_i;
    logic         bus_stb_i;
    logic         bus_we_i;
    logic [7:0]   bus_adr_i;
    logic [31:0]  bus_dat_i;
    logic [31:0]  bus_dat_o;
    logic         bus_ack_o;

    logic [31:0]  lfsr;
    logic [31:0]  dummy;
    int           errors;
    int           timeouts;

    bq_capture_top uut (.*);

    always #4 aclk = ~aclk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [W-1:0] w);
        for (int i = 0; i < W; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    function automatic logic [31:0] sign_extend(input logic [31:0] v);
        return {{(32 - `BQ_CBITS){v[`BQ_CBITS-1]}}, v[`BQ_CBITS-1:0]};
    endfunction

    // fresh ADC words on both channels every cycle
    always @(negedge aclk) begin
        random_word(adc0_tdata_i);
        random_word(adc1_tdata_i);
    end

    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge aclk);
        bus_cyc_i = 1'b1;
        bus_stb_i = 1'b1;
        bus_we_i  = we;
        bus_adr_i = adr;
        bus_dat_i = wdata;
        @(negedge aclk);
        while (!bus_ack_o && n < ACK_TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (!bus_ack_o) begin
            $display("timeout: no bus acknowledge for address %02h", adr);
            timeouts++;
        end
        rdata     = bus_dat_o;
        bus_cyc_i = 1'b0;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
    endtask

    task automatic check_read(input logic [7:0] adr, input logic [31:0] expected);
        logic [31:0] got;
        bus_access(1'b0, adr, 32'h0, got);
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: bus_dat_o at address %02h is %08h, expected %08h",
                     $time, adr, got, expected);
        end
    endtask

    task automatic load_coefs(input logic ch, input logic [31:0] b0,
                              input logic [31:0] b1, input logic [31:0] b2);
        logic [31:0] vals [3];
        logic [31:0] wr_back;
        vals[0] = b0;
        vals[1] = b1;
        vals[2] = b2;
        for (int i = 0; i < 3; i++) begin
            bus_access(1'b1, {ch, 5'd0, 2'(i)}, vals[i], wr_back);
            check_read({ch, 5'd0, 2'(i)}, sign_extend(vals[i]));
        end
    endtask

    task automatic pulse_capture();
        @(negedge aclk);
        capture_i = 1'b1;
        @(negedge aclk);
        capture_i = 1'b0;
    endtask

    // the filter clear marks the end of a capture cycle
    task automatic wait_window_done();
        int n;
        n = 0;
        while (uut.fir_clear !== 1'b1 && n < RUN_TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (uut.fir_clear !== 1'b1) begin
            $display("timeout: capture window never reached the filter clear");
            timeouts++;
        end
        @(negedge aclk);
    endtask

    initial begin
        aclk          = 1'b0;
        rst_i         = 1'b1;
        capture_i     = 1'b0;
        adc0_tdata_i  = '0;
        adc0_tvalid_i = 1'b1;
        adc1_tdata_i  = '0;
        adc1_tvalid_i = 1'b1;
        bus_cyc_i     = 1'b0;
        bus_stb_i     = 1'b0;
        bus_we_i      = 1'b0;
        bus_adr_i     = '0;
        bus_dat_i     = '0;
        lfsr          = 32'd97031;
        errors        = 0;
        timeouts      = 0;
        repeat (10) @(negedge aclk);
        rst_i = 1'b0;
        repeat (4) @(negedge aclk);

        // upper data bits are dropped, readback is sign-extended
        load_coefs(1'b0, 32'hffff_e000, 32'h7ff1_ffff, 32'h0002_0000);
        load_coefs(1'b1, 32'h0000_1234, 32'h8003_ffff, 32'h0001_0001);
        bus_access(1'b1, 8'h03, 32'h0000_5555, dummy);
        check_read(8'h03, 32'h0);
        check_read(8'h83, 32'h0);
        check_read(8'h04, 32'h0);
        check_read(8'h7c, 32'h0);
        // b2 sits next to the unmapped slot and must keep its value
        check_read(8'h02, sign_extend(32'h0002_0000));

        // unity on channel 0, mixed taps on channel 1
        load_coefs(1'b0, 32'd16384, 32'd0, 32'd0);
        load_coefs(1'b1, 32'd8192, 32'hffff_e890, 32'd3000);
        pulse_capture();
        repeat (60) @(negedge aclk);
        // lands inside the open window and must not extend it
        pulse_capture();
        wait_window_done();

        // large gains drive the lanes into saturation
        load_coefs(1'b0, 32'h0001_ffff, 32'h0001_ffff, 32'h0001_ffff);
        load_coefs(1'b1, 32'h0002_0000, 32'h0001_ffff, 32'h0002_0000);
        pulse_capture();
        wait_window_done();
        repeat (8) @(negedge aclk);

        $display("errors: %0d readback, %0d timeout, %0d assertion",
                 errors, timeouts, uut.u_props.fail_count);
        if (errors == 0 && timeouts == 0 && uut.u_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* test/bq_capture_properties.sv */
`include "bq_defs.svh"

module bq_capture_properties (
    input logic                    aclk,
    input logic                    rst_i,
    input logic                    capture_i,
    input logic [16*`BQ_NSAMP-1:0] adc0_i,
    input logic [16*`BQ_NSAMP-1:0] adc1_i,
    input logic [16*`BQ_NSAMP-1:0] buf0_i,
    input logic [16*`BQ_NSAMP-1:0] buf1_i,
    input logic [16*`BQ_NSAMP-1:0] buf2_i,
    input logic [16*`BQ_NSAMP-1:0] buf3_i,
    input logic [3:0]              valid_i,
    input logic                    bus_cyc_i,
    input logic                    bus_stb_i,
    input logic                    bus_we_i,
    input logic [7:0]              bus_adr_i,
    input logic [31:0]             bus_dat_i,
    input logic                    bus_ack_i,
    input logic                    fir_clear_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W         = 16 * `BQ_NSAMP;
    localparam int LSB       = 16 - `BQ_NBITS;
    // counted in edges after the capture edge, as seen by buf0 and buf1
    localparam int WIN_FIRST = `BQ_GATE_DELAY + 2;
    localparam int WIN_LAST  = `BQ_GATE_DELAY + `BQ_GATE_LEN + 1;
    localparam int BUSY_LEN  = `BQ_GATE_DELAY + `BQ_GATE_LEN + `BQ_RST_DELAY;
    localparam longint SMAX  = (1 << (`BQ_NBITS - 1)) - 1;
    localparam longint SMIN  = -(1 << (`BQ_NBITS - 1));
    localparam logic [W-1:0] PAD_MASK = {`BQ_NSAMP{16'((1 << LSB) - 1)}};

    int                          fail_count;
    logic                        busy;
    int                          age;
    logic                        in_win;
    logic                        tail;
    logic signed [`BQ_CBITS-1:0] cf [6];
    logic [W-1:0]                last0;
    logic [W-1:0]                last1;
    logic [W-1:0]                exp0;
    logic [W-1:0]                exp1;

    initial fail_count = 0;

    function automatic longint sample_of(input logic [W-1:0] w, input int k);
        return longint'($signed(w[16*k+LSB +: `BQ_NBITS]));
    endfunction

    // three taps per lane, lanes 0 and 1 reach into the previous word
    function automatic logic [W-1:0] fir_expect(input logic [W-1:0] cur,
                                                input logic [W-1:0] prev,
                                                input longint b0,
                                                input longint b1,
                                                input longint b2);
        logic [W-1:0] res;
        longint       x [`BQ_NSAMP+2];
        longint       acc;
        res  = '0;
        x[0] = sample_of(prev, `BQ_NSAMP - 2);
        x[1] = sample_of(prev, `BQ_NSAMP - 1);
        for (int k = 0; k < `BQ_NSAMP; k++) begin
            x[k+2] = sample_of(cur, k);
        end
        for (int k = 0; k < `BQ_NSAMP; k++) begin
            acc = b0 * x[k+2] + b1 * x[k+1] + b2 * x[k] + (longint'(1) <<< (`BQ_CFRAC - 1));
            acc = acc >>> `BQ_CFRAC;
            if (acc > SMAX) begin
                acc = SMAX;
            end
            if (acc < SMIN) begin
                acc = SMIN;
            end
            res[16*k+LSB +: `BQ_NBITS] = acc[`BQ_NBITS-1:0];
        end
        return res;
    endfunction

    // window timing and coefficient map seen from the ports
    always_ff @(posedge aclk) begin
        last0 <= buf0_i;
        last1 <= buf1_i;
        if (rst_i) begin
            busy <= 1'b0;
            age  <= 0;
            for (int i = 0; i < 6; i++) begin
                cf[i] <= '0;
            end
        end else begin
            if (!busy && capture_i) begin
                busy <= 1'b1;
                age  <= 1;
            end else if (busy && age == BUSY_LEN) begin
                busy <= 1'b0;
            end else if (busy) begin
                age <= age + 1;
            end
            if (bus_cyc_i && bus_stb_i && bus_we_i && bus_adr_i[6:2] == '0 &&
                bus_adr_i[1:0] != 2'd3) begin
                cf[3 * int'(bus_adr_i[7]) + int'(bus_adr_i[1:0])] <= bus_dat_i[`BQ_CBITS-1:0];
            end
        end
    end

    assign in_win = busy && age >= WIN_FIRST && age <= WIN_LAST;
    // first word after a window, its history was dropped at the window end
    assign tail   = busy && age == WIN_LAST + 1;

    always_comb begin
        exp0 = fir_expect(buf0_i, tail ? '0 : last0, cf[0], cf[1], cf[2]);
        exp1 = fir_expect(buf1_i, tail ? '0 : last1, cf[3], cf[4], cf[5]);
    end

    quiet_in_reset: assert property (@(posedge aclk)
        rst_i |=> (valid_i == 4'b0) && !bus_ack_i)
        else begin fail_count++; $error("output valid or bus ack high during reset"); end

    valid_after_reset: assert property (@(posedge aclk) disable iff (rst_i)
        !$past(rst_i, 1) && !$past(rst_i, 2) && !$past(rst_i, 3) |-> &valid_i)
        else begin fail_count++; $error("output valid low after reset"); end

    gate_ch0: assert property (@(posedge aclk) disable iff (rst_i)
        buf0_i == (in_win ? $past(adc0_i) : '0))
        else begin fail_count++; $error("buf0 word breaks the gate window"); end

    gate_ch1: assert property (@(posedge aclk) disable iff (rst_i)
        buf1_i == (in_win ? $past(adc1_i) : '0))
        else begin fail_count++; $error("buf1 word breaks the gate window"); end

    clear_pulse: assert property (@(posedge aclk) disable iff (rst_i)
        fir_clear_i == $past(busy && age == BUSY_LEN))
        else begin fail_count++; $error("filter clear pulse at the wrong cycle"); end

    filter_ch0: assert property (@(posedge aclk) disable iff (rst_i)
        buf2_i == $past(exp0, 2))
        else begin fail_count++; $error("buf2 differs from the three-tap sum"); end

    filter_ch1: assert property (@(posedge aclk) disable iff (rst_i)
        buf3_i == $past(exp1, 2))
        else begin fail_count++; $error("buf3 differs from the three-tap sum"); end

    padding: assert property (@(posedge aclk) disable iff (rst_i)
        (buf2_i & PAD_MASK) == '0 && (buf3_i & PAD_MASK) == '0)
        else begin fail_count++; $error("padding bits set on a filtered lane"); end

    ack_follows: assert property (@(posedge aclk) disable iff (rst_i)
        bus_cyc_i && bus_stb_i && !bus_ack_i |=> bus_ack_i)
        else begin fail_count++; $error("bus access not acked one cycle later"); end

    ack_single: assert property (@(posedge aclk) disable iff (rst_i)
        bus_ack_i |=> !bus_ack_i)
        else begin fail_count++; $error("bus ack held longer than one cycle"); end

    ack_requested: assert property (@(posedge aclk) disable iff (rst_i)
        bus_ack_i |-> $past(bus_cyc_i && bus_stb_i))
        else begin fail_count++; $error("bus ack without a strobe"); end

endmodule

bind bq_capture_top bq_capture_properties u_props (
    .aclk        (aclk),
    .rst_i       (rst_i),
    .capture_i   (capture_i),
    .adc0_i      (adc0_tdata_i),
    .adc1_i      (adc1_tdata_i),
    .buf0_i      (buf0_tdata_o),
    .buf1_i      (buf1_tdata_o),
    .buf2_i      (buf2_tdata_o),
    .buf3_i      (buf3_tdata_o),
    .valid_i     ({buf3_tvalid_o, buf2_tvalid_o, buf1_tvalid_o, buf0_tvalid_o}),
    .bus_cyc_i   (bus_cyc_i),
    .bus_stb_i   (bus_stb_i),
    .bus_we_i    (bus_we_i),
    .bus_adr_i   (bus_adr_i),
    .bus_dat_i   (bus_dat_i),
    .bus_ack_i   (bus_ack_o),
    .fir_clear_i (fir_clear)
);

/* design/bq_capture_top.sv */
`include "bq_defs.svh"

module bq_capture_top
    import bq_pkg::*;
(
    input  logic                         aclk,
    input  logic                         rst_i,
    input  logic                         capture_i,
    input  logic [$bits(adc_word_t)-1:0] adc0_tdata_i,
    input  logic                         adc0_tvalid_i,
    input  logic [$bits(adc_word_t)-1:0] adc1_tdata_i,
    input  logic                         adc1_tvalid_i,
    output logic [$bits(adc_word_t)-1:0] buf0_tdata_o,
    output logic                         buf0_tvalid_o,
    output logic [$bits(adc_word_t)-1:0] buf1_tdata_o,
    output logic                         buf1_tvalid_o,
    output logic [$bits(adc_word_t)-1:0] buf2_tdata_o,
    output logic                         buf2_tvalid_o,
    output logic [$bits(adc_word_t)-1:0] buf3_tdata_o,
    output logic                         buf3_tvalid_o,
    input  logic                         bus_cyc_i,
    input  logic                         bus_stb_i,
    input  logic                         bus_we_i,
    input  logic [7:0]                   bus_adr_i,
    input  logic [31:0]                  bus_dat_i,
    output logic [31:0]                  bus_dat_o,
    output logic                         bus_ack_o
);

    adc_word_t   adc0_w;
    adc_word_t   adc1_w;
    adc_word_t   raw0;
    adc_word_t   raw1;
    coef_set_t   coef0;
    coef_set_t   coef1;
    logic        fir_clear;
    sample_vec_t fir_out [2];
    logic        fir_valid [2];
    adc_word_t   packed_w [2];

    bq_stream_if gs0 ();
    bq_stream_if gs1 ();

    // a beat without tvalid counts as silence
    assign adc0_w.raw = adc0_tvalid_i ? adc0_tdata_i : '0;
    assign adc1_w.raw = adc1_tvalid_i ? adc1_tdata_i : '0;

    capture_gate u_gate (
        .aclk        (aclk),
        .rst_i       (rst_i),
        .capture_i   (capture_i),
        .adc0_i      (adc0_w),
        .adc1_i      (adc1_w),
        .raw0_o      (raw0),
        .raw1_o      (raw1),
        .gs0         (gs0.source),
        .gs1         (gs1.source),
        .fir_clear_o (fir_clear)
    );

    coef_regs u_regs (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .bus_cyc_i (bus_cyc_i),
        .bus_stb_i (bus_stb_i),
        .bus_we_i  (bus_we_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_dat_o (bus_dat_o),
        .bus_ack_o (bus_ack_o),
        .coef0_o   (coef0),
        .coef1_o   (coef1)
    );

    zero_fir u_fir0 (
        .aclk        (aclk),
        .rst_i       (rst_i),
        .clear_i     (fir_clear),
        .coef_i      (coef0),
        .s           (gs0.sink),
        .out_o       (fir_out[0]),
        .out_valid_o (fir_valid[0])
    );

    zero_fir u_fir1 (
        .aclk        (aclk),
        .rst_i       (rst_i),
        .clear_i     (fir_clear),
        .coef_i      (coef1),
        .s           (gs1.sink),
        .out_o       (fir_out[1]),
        .out_valid_o (fir_valid[1])
    );

    // back to 16-bit lanes with zero padding
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < `BQ_NSAMP; i++) begin
                packed_w[c].lane[i].smp = fir_out[c][i];
                packed_w[c].lane[i].pad = '0;
            end
        end
    end

    // raw words already carry their one-cycle latency from the gate,
    // the filter adds its own two stages behind them
    assign buf0_tdata_o  = raw0.raw;
    assign buf0_tvalid_o = gs0.valid;
    assign buf1_tdata_o  = raw1.raw;
    assign buf1_tvalid_o = gs1.valid;
    assign buf2_tdata_o  = packed_w[0].raw;
    assign buf2_tvalid_o = fir_valid[0];
    assign buf3_tdata_o  = packed_w[1].raw;
    assign buf3_tvalid_o = fir_valid[1];

endmodule

/* design/zero_fir.sv */
`include "bq_defs.svh"

module zero_fir
    import bq_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_i,
    input  logic        clear_i,
    input  coef_set_t   coef_i,
    bq_stream_if.sink   s,
    output sample_vec_t out_o,
    output logic        out_valid_o
);

    localparam int N    = `BQ_NSAMP;
    localparam int PW   = `BQ_NBITS + `BQ_CBITS;
    // three products need two guard bits
    localparam int SW   = PW + 2;
    localparam int QW   = SW - `BQ_CFRAC;
    localparam int HALF = 1 << (`BQ_CFRAC - 1);
    localparam int OMAX = (1 << (`BQ_NBITS - 1)) - 1;
    localparam int OMIN = -(1 << (`BQ_NBITS - 1));

    // x_ext[k+2] is lane k, x_ext[1] and x_ext[0] come from the previous word
    sample_t              x_ext [N+2];
    sample_t              hist [2];
    logic signed [PW-1:0] p0_q [N];
    logic signed [PW-1:0] p1_q [N];
    logic signed [PW-1:0] p2_q [N];
    logic signed [SW-1:0] acc [N];
    logic signed [QW-1:0] q [N];
    logic                 v1_q;

    function automatic sample_t sat(input logic signed [QW-1:0] v);
        if (v > OMAX) begin
            return OMAX[`BQ_NBITS-1:0];
        end
        if (v < OMIN) begin
            return OMIN[`BQ_NBITS-1:0];
        end
        return v[`BQ_NBITS-1:0];
    endfunction

    always_comb begin
        // a window never looks back past its own first word
        x_ext[0] = s.win_start ? '0 : hist[0];
        x_ext[1] = s.win_start ? '0 : hist[1];
        for (int k = 0; k < N; k++) begin
            x_ext[k+2] = s.samples[k];
        end
    end

    // cross-word history, the two newest lanes
    always_ff @(posedge aclk) begin
        if (rst_i || clear_i) begin
            hist[0] <= '0;
            hist[1] <= '0;
        end else if (s.valid) begin
            hist[0] <= s.win_end ? '0 : s.samples[N-2];
            hist[1] <= s.win_end ? '0 : s.samples[N-1];
        end
    end

    // stage 1 registers the products
    always_ff @(posedge aclk) begin
        for (int k = 0; k < N; k++) begin
            p0_q[k] <= PW'(coef_i.b0) * PW'(x_ext[k+2]);
            p1_q[k] <= PW'(coef_i.b1) * PW'(x_ext[k+1]);
            p2_q[k] <= PW'(coef_i.b2) * PW'(x_ext[k]);
        end
    end

    always_comb begin
        for (int k = 0; k < N; k++) begin
            acc[k] = SW'(p0_q[k]) + SW'(p1_q[k]) + SW'(p2_q[k]) + SW'(HALF);
            q[k]   = QW'(acc[k] >>> `BQ_CFRAC);
        end
    end

    // stage 2 rounds and saturates
    always_ff @(posedge aclk) begin
        for (int k = 0; k < N; k++) begin
            out_o[k] <= sat(q[k]);
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            v1_q        <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            v1_q        <= s.valid;
            out_valid_o <= v1_q;
        end
    end

endmodule

/* design/coef_regs.sv */
`include "bq_defs.svh"

module coef_regs
    import bq_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_i,
    input  logic        bus_cyc_i,
    input  logic        bus_stb_i,
    input  logic        bus_we_i,
    input  logic [7:0]  bus_adr_i,
    input  logic [31:0] bus_dat_i,
    output logic [31:0] bus_dat_o,
    output logic        bus_ack_o,
    output coef_set_t   coef0_o,
    output coef_set_t   coef1_o
);

    coef_set_t coef_q [2];
    logic      req;
    logic      ch;
    logic      hit;
    coef_t     rd;
    coef_t     wr;

    // a new access starts only while no ack is out
    assign req = bus_cyc_i && bus_stb_i && !bus_ack_o;
    // bit 7 picks the channel
    assign ch  = bus_adr_i[7];
    assign hit = (bus_adr_i[6:2] == '0) && (bus_adr_i[1:0] != 2'd3);
    assign wr  = bus_dat_i[`BQ_CBITS-1:0];

    always_comb begin
        case (bus_adr_i[1:0])
            2'd0:    rd = coef_q[ch].b0;
            2'd1:    rd = coef_q[ch].b1;
            default: rd = coef_q[ch].b2;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            coef_q[0] <= '0;
            coef_q[1] <= '0;
            bus_ack_o <= 1'b0;
            bus_dat_o <= '0;
        end else begin
            bus_ack_o <= req;
            if (req) begin
                // sign-extended readback, unmapped reads give zero
                bus_dat_o <= hit ? 32'(rd) : '0;
            end
            if (req && bus_we_i && hit) begin
                case (bus_adr_i[1:0])
                    2'd0:    coef_q[ch].b0 <= wr;
                    2'd1:    coef_q[ch].b1 <= wr;
                    default: coef_q[ch].b2 <= wr;
                endcase
            end
        end
    end

    assign coef0_o = coef_q[0];
    assign coef1_o = coef_q[1];

endmodule

/* design/capture_gate.sv */
`include "bq_defs.svh"

module capture_gate
    import bq_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_i,
    input  logic        capture_i,
    input  adc_word_t   adc0_i,
    input  adc_word_t   adc1_i,
    output adc_word_t   raw0_o,
    output adc_word_t   raw1_o,
    bq_stream_if.source gs0,
    bq_stream_if.source gs1,
    output logic        fir_clear_o
);

    localparam int CNT_W = $clog2(`BQ_GATE_DELAY + `BQ_GATE_LEN + `BQ_RST_DELAY);

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_PRE  = 2'd1;
    localparam logic [1:0] PH_WIN  = 2'd2;
    localparam logic [1:0] PH_POST = 2'd3;

    logic [1:0]       phase;
    logic [CNT_W-1:0] cnt;
    logic             gate;
    logic             first;
    logic             last;
    logic             valid_q;
    logic             start_q;
    logic             end_q;
    logic             clear_q;
    adc_word_t        rereg0;
    adc_word_t        rereg1;

    function automatic sample_vec_t unpack(input adc_word_t w);
        sample_vec_t v;
        for (int i = 0; i < `BQ_NSAMP; i++) begin
            v[i] = w.lane[i].smp;
        end
        return v;
    endfunction

    assign gate  = (phase == PH_WIN);
    assign first = gate && (cnt == '0);
    assign last  = gate && (cnt == CNT_W'(`BQ_GATE_LEN - 1));

    // one counter walks through delay, window and post-window delay
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            phase   <= PH_IDLE;
            cnt     <= '0;
            clear_q <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    // captures outside idle are dropped
                    if (capture_i) begin
                        phase <= PH_PRE;
                        cnt   <= '0;
                    end
                end
                PH_PRE: begin
                    if (cnt == CNT_W'(`BQ_GATE_DELAY - 1)) begin
                        phase <= PH_WIN;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PH_WIN: begin
                    if (last) begin
                        phase <= PH_POST;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == CNT_W'(`BQ_RST_DELAY - 1)) begin
                        phase   <= PH_IDLE;
                        cnt     <= '0;
                        clear_q <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // closed gate sends silence
    always_ff @(posedge aclk) begin
        rereg0 <= gate ? adc0_i : '0;
        rereg1 <= gate ? adc1_i : '0;
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            start_q <= 1'b0;
            end_q   <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            start_q <= first;
            end_q   <= last;
        end
    end

    assign raw0_o = rereg0;
    assign raw1_o = rereg1;

    assign gs0.valid     = valid_q;
    assign gs0.samples   = unpack(rereg0);
    assign gs0.win_start = start_q;
    assign gs0.win_end   = end_q;

    assign gs1.valid     = valid_q;
    assign gs1.samples   = unpack(rereg1);
    assign gs1.win_start = start_q;
    assign gs1.win_end   = end_q;

    assign fir_clear_o = clear_q;

endmodule

/* design/bq_stream_if.sv */
interface bq_stream_if
    import bq_pkg::*;
();

    logic        valid;
    sample_vec_t samples;
    // first and last beats of a capture window
    logic        win_start;
    logic        win_end;

    // no ready, the sink takes every valid beat
    modport source (
        output valid,
        output samples,
        output win_start,
        output win_end
    );

    modport sink (
        input valid,
        input samples,
        input win_start,
        input win_end
    );

endinterface

/* design/bq_pkg.sv */
`include "bq_defs.svh"

package bq_pkg;

    // one ADC sample
    typedef logic signed [`BQ_NBITS-1:0] sample_t;

    typedef logic signed [`BQ_CBITS-1:0] coef_t;

    // one 16-bit lane of an ADC word, sample in the upper bits
    typedef struct packed {
        sample_t                   smp;
        logic [16-`BQ_NBITS-1:0]   pad;
    } adc_lane_t;

    // the 128-bit stream word, seen as a flat vector or as lanes
    typedef union packed {
        logic [16*`BQ_NSAMP-1:0]        raw;
        adc_lane_t [`BQ_NSAMP-1:0]      lane;
    } adc_word_t;

    // lane 0 is the oldest sample of the word
    typedef sample_t [`BQ_NSAMP-1:0] sample_vec_t;

    // zero-section taps, b0 applies to the newest sample
    typedef struct packed {
        coef_t b0;
        coef_t b1;
        coef_t b2;
    } coef_set_t;

endpackage

/* design/bq_defs.svh */
`ifndef BQ_DEFS_SVH
`define BQ_DEFS_SVH

// samples carried per clock in each ADC word
`define BQ_NSAMP 8

// ADC sample width, left-justified in a 16-bit lane
`define BQ_NBITS 12

// filter coefficients, signed fixed point
`define BQ_CBITS 18
`define BQ_CFRAC 14

// capture window timing, in aclk cycles
`define BQ_GATE_DELAY 32
`define BQ_GATE_LEN 64

// counted from the last gated word to the filter clear pulse
`define BQ_RST_DELAY 32

`endif
